// File: rtl/rfdc_pkg.sv
package rfdc_pkg;

    localparam int RFDC_BITS = 16;

    typedef logic [17:0]          addr_t;
    typedef logic [31:0]          data_t;
    typedef logic [3:0]           strb_t;
    typedef logic [1:0]           resp_t;
    typedef logic [RFDC_BITS-1:0] lane_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // axi4-lite channel payloads
    typedef struct packed {
        addr_t addr;
    } axil_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axil_w_t;

    typedef struct packed {
        resp_t resp;
    } axil_b_t;

    typedef struct packed {
        addr_t addr;
    } axil_ar_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } axil_r_t;

    // converter control register map
    localparam addr_t REG_ID         = 18'h00;
    localparam addr_t REG_CHAN_EN    = 18'h04;
    localparam addr_t REG_SCRATCH    = 18'h08;
    localparam addr_t REG_SYSREF_CNT = 18'h0C;

    // reads back as ascii "RFDC"
    localparam data_t RFDC_ID = 32'h5246_4443;

    typedef enum logic [1:0] {
        IDLE,
        AXI_BEGIN,
        AXI_WAIT,
        ACK
    } bridge_state_t;

endpackage

// File: rtl/wb_axil_bridge.sv
`timescale 1ns/1ps

module wb_axil_bridge import rfdc_pkg::*; (
    input  logic     wb_clk_i,
    input  logic     rst_n_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  addr_t    wb_adr_i,
    input  strb_t    wb_sel_i,
    input  data_t    wb_dat_i,
    output data_t    wb_dat_o,
    output logic     wb_ack_o,
    output logic     bridge_err_o,
    output axil_aw_t aw_o,
    output logic     aw_valid_o,
    input  logic     aw_ready_i,
    output axil_w_t  w_o,
    output logic     w_valid_o,
    input  logic     w_ready_i,
    input  axil_b_t  b_i,
    input  logic     b_valid_i,
    output logic     b_ready_o,
    output axil_ar_t ar_o,
    output logic     ar_valid_o,
    input  logic     ar_ready_i,
    input  axil_r_t  r_i,
    input  logic     r_valid_i,
    output logic     r_ready_o
);

    bridge_state_t state;
    logic          is_wr;
    logic          aw_done;
    logic          w_done;
    logic          ar_done;
    logic          b_hs;
    logic          r_hs;

    // wishbone holds its payload until ack, so it goes straight out
    assign aw_o = '{addr: wb_adr_i};
    assign ar_o = '{addr: wb_adr_i};
    assign w_o  = '{data: wb_dat_i, strb: wb_sel_i};

    // aw and w go up together, each drops on its own handshake
    assign aw_valid_o = (state == AXI_BEGIN) && is_wr && !aw_done;
    assign w_valid_o  = (state == AXI_BEGIN) && is_wr && !w_done;
    assign ar_valid_o = (state == AXI_BEGIN) && !is_wr && !ar_done;

    assign b_ready_o = (state == AXI_WAIT) && is_wr;
    // read response is only taken in the ack cycle
    assign r_ready_o = (state == ACK) && !is_wr;
    assign wb_ack_o  = (state == ACK);

    assign b_hs = b_valid_i && b_ready_o;
    assign r_hs = r_valid_i && r_ready_o;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state        <= IDLE;
            is_wr        <= 1'b0;
            aw_done      <= 1'b0;
            w_done       <= 1'b0;
            ar_done      <= 1'b0;
            bridge_err_o <= 1'b0;
        end else begin
            bridge_err_o <= (b_hs && b_i.resp == RESP_SLVERR) ||
                            (r_hs && r_i.resp == RESP_SLVERR);
            case (state)
                IDLE: begin
                    if (wb_cyc_i && wb_stb_i) begin
                        is_wr <= wb_we_i;
                        state <= AXI_BEGIN;
                    end
                end
                AXI_BEGIN: begin
                    if (aw_valid_o && aw_ready_i) begin
                        aw_done <= 1'b1;
                    end
                    if (w_valid_o && w_ready_i) begin
                        w_done <= 1'b1;
                    end
                    if (ar_valid_o && ar_ready_i) begin
                        ar_done <= 1'b1;
                    end
                    if (is_wr ? (aw_done && w_done) : ar_done) begin
                        state <= AXI_WAIT;
                    end
                end
                AXI_WAIT: begin
                    if (b_hs || (!is_wr && r_valid_i)) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    ar_done <= 1'b0;
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // read data held from r valid through the ack cycle
    always_ff @(posedge wb_clk_i) begin
        if (state == AXI_WAIT && !is_wr && r_valid_i) begin
            wb_dat_o <= r_i.data;
        end
    end

    assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o);

    assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        aw_valid_o && !aw_ready_i |=> aw_valid_o);

    assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        w_valid_o && !w_ready_i |=> w_valid_o);

    assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o);

endmodule

// File: rtl/axil_reg_slice.sv
`timescale 1ns/1ps

module axil_reg_slice import rfdc_pkg::*; (
    input  logic     wb_clk_i,
    input  logic     rst_n_i,
    input  axil_aw_t s_aw_i,
    input  logic     s_aw_valid_i,
    output logic     s_aw_ready_o,
    input  axil_w_t  s_w_i,
    input  logic     s_w_valid_i,
    output logic     s_w_ready_o,
    output axil_b_t  s_b_o,
    output logic     s_b_valid_o,
    input  logic     s_b_ready_i,
    input  axil_ar_t s_ar_i,
    input  logic     s_ar_valid_i,
    output logic     s_ar_ready_o,
    output axil_r_t  s_r_o,
    output logic     s_r_valid_o,
    input  logic     s_r_ready_i,
    output axil_aw_t m_aw_o,
    output logic     m_aw_valid_o,
    input  logic     m_aw_ready_i,
    output axil_w_t  m_w_o,
    output logic     m_w_valid_o,
    input  logic     m_w_ready_i,
    input  axil_b_t  m_b_i,
    input  logic     m_b_valid_i,
    output logic     m_b_ready_o,
    output axil_ar_t m_ar_o,
    output logic     m_ar_valid_o,
    input  logic     m_ar_ready_i,
    input  axil_r_t  m_r_i,
    input  logic     m_r_valid_i,
    output logic     m_r_ready_o
);

    localparam int NCH = 5;
    localparam int PW  = $bits(axil_w_t);

    typedef logic [PW-1:0] pl_t;

    // channel order aw, w, b, ar, r; b and r flow back toward the bridge
    pl_t            in_pl  [NCH];
    pl_t            out_pl [NCH];
    logic [NCH-1:0] in_valid;
    logic [NCH-1:0] in_ready;
    logic [NCH-1:0] out_valid;
    logic [NCH-1:0] out_ready;

    assign in_pl[0] = PW'(s_aw_i);
    assign in_pl[1] = PW'(s_w_i);
    assign in_pl[2] = PW'(m_b_i);
    assign in_pl[3] = PW'(s_ar_i);
    assign in_pl[4] = PW'(m_r_i);

    assign in_valid  = {m_r_valid_i, s_ar_valid_i, m_b_valid_i, s_w_valid_i, s_aw_valid_i};
    assign out_ready = {s_r_ready_i, m_ar_ready_i, s_b_ready_i, m_w_ready_i, m_aw_ready_i};

    assign s_aw_ready_o = in_ready[0];
    assign s_w_ready_o  = in_ready[1];
    assign m_b_ready_o  = in_ready[2];
    assign s_ar_ready_o = in_ready[3];
    assign m_r_ready_o  = in_ready[4];

    assign m_aw_valid_o = out_valid[0];
    assign m_w_valid_o  = out_valid[1];
    assign s_b_valid_o  = out_valid[2];
    assign m_ar_valid_o = out_valid[3];
    assign s_r_valid_o  = out_valid[4];

    assign m_aw_o = out_pl[0][$bits(axil_aw_t)-1:0];
    assign m_w_o  = out_pl[1][$bits(axil_w_t)-1:0];
    assign s_b_o  = out_pl[2][$bits(axil_b_t)-1:0];
    assign m_ar_o = out_pl[3][$bits(axil_ar_t)-1:0];
    assign s_r_o  = out_pl[4][$bits(axil_r_t)-1:0];

    for (genvar i = 0; i < NCH; i++) begin : g_chan
        logic full;
        pl_t  entry;

        // refill in the same cycle the entry drains
        assign in_ready[i]  = !full || out_ready[i];
        assign out_valid[i] = full;
        assign out_pl[i]    = entry;

        always_ff @(posedge wb_clk_i) begin
            if (!rst_n_i) begin
                full <= 1'b0;
            end else if (in_valid[i] && in_ready[i]) begin
                full <= 1'b1;
            end else if (out_ready[i]) begin
                full <= 1'b0;
            end
        end

        always_ff @(posedge wb_clk_i) begin
            if (in_valid[i] && in_ready[i]) begin
                entry <= in_pl[i];
            end
        end

        // upstream must hold a stalled item
        assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
            in_valid[i] && !in_ready[i] |=> in_valid[i] && $stable(in_pl[i]));
    end

endmodule

// File: rtl/conv_ctrl_regs.sv
`timescale 1ns/1ps

module conv_ctrl_regs import rfdc_pkg::*; #(
    parameter int NCHAN = 8
) (
    input  logic             wb_clk_i,
    input  logic             rst_n_i,
    input  axil_aw_t         aw_i,
    input  logic             aw_valid_i,
    output logic             aw_ready_o,
    input  axil_w_t          w_i,
    input  logic             w_valid_i,
    output logic             w_ready_o,
    output axil_b_t          b_o,
    output logic             b_valid_o,
    input  logic             b_ready_i,
    input  axil_ar_t         ar_i,
    input  logic             ar_valid_i,
    output logic             ar_ready_o,
    output axil_r_t          r_o,
    output logic             r_valid_o,
    input  logic             r_ready_i,
    input  logic             sysref_i,
    output logic [NCHAN-1:0] chan_en_o
);

    logic  wr_rdy;
    logic  wr_go;
    logic  rd_go;
    logic  b_pend;
    logic  r_pend;
    logic  wr_ok;
    data_t scratch;
    data_t sysref_cnt;
    logic  sysref_q;
    data_t rd_data;
    resp_t rd_resp;

    assign aw_ready_o = wr_rdy;
    assign w_ready_o  = wr_rdy;

    // a write needs address and data in the same cycle
    assign wr_go  = aw_valid_i && w_valid_i && aw_ready_o && w_ready_o;
    assign rd_go  = ar_valid_i && ar_ready_o;
    assign b_pend = wr_go || (b_valid_o && !b_ready_i);
    assign r_pend = rd_go || (r_valid_o && !r_ready_i);

    // id and sysref count are read only
    assign wr_ok = (aw_i.addr == REG_CHAN_EN) || (aw_i.addr == REG_SCRATCH);

    always_comb begin
        rd_resp = RESP_OKAY;
        case (ar_i.addr)
            REG_ID:         rd_data = RFDC_ID;
            REG_CHAN_EN:    rd_data = data_t'(chan_en_o);
            REG_SCRATCH:    rd_data = scratch;
            REG_SYSREF_CNT: rd_data = sysref_cnt;
            default: begin
                rd_data = '0;
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    // ready drops for as long as a response is outstanding
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            wr_rdy     <= 1'b0;
            ar_ready_o <= 1'b0;
            b_valid_o  <= 1'b0;
            r_valid_o  <= 1'b0;
        end else begin
            b_valid_o  <= b_pend;
            wr_rdy     <= !b_pend;
            r_valid_o  <= r_pend;
            ar_ready_o <= !r_pend;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wr_go) begin
            b_o <= '{resp: wr_ok ? RESP_OKAY : RESP_SLVERR};
        end
        if (rd_go) begin
            r_o <= '{data: rd_data, resp: rd_resp};
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            chan_en_o  <= '1;
            scratch    <= '0;
            sysref_q   <= 1'b0;
            sysref_cnt <= '0;
        end else begin
            sysref_q <= sysref_i;
            // rising edges only
            if (sysref_i && !sysref_q) begin
                sysref_cnt <= sysref_cnt + data_t'(1);
            end
            if (wr_go && aw_i.addr == REG_CHAN_EN) begin
                chan_en_o <= w_i.data[NCHAN-1:0];
            end
            if (wr_go && aw_i.addr == REG_SCRATCH) begin
                for (int i = 0; i < 4; i++) begin
                    if (w_i.strb[i]) begin
                        scratch[8*i +: 8] <= w_i.data[8*i +: 8];
                    end
                end
            end
        end
    end

    // upstream keeps aw and w in step
    assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        aw_valid_i == w_valid_i);

    assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        b_valid_o && !b_ready_i |=> !wr_go);

    assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        r_valid_o && !r_ready_i |=> !rd_go);

endmodule

// File: rtl/sample_unpack.sv
`timescale 1ns/1ps

module sample_unpack import rfdc_pkg::*; #(
    parameter int NCHAN = 8,
    parameter int NSAMP = 8,
    parameter int NBITS = 12
) (
    input  logic                         wb_clk_i,
    input  logic                         rst_n_i,
    input  lane_t [NCHAN*NSAMP-1:0]      adc_tdata_i,
    input  logic                         adc_tvalid_i,
    input  logic [NCHAN-1:0]             chan_en_i,
    output logic [NCHAN*NSAMP*NBITS-1:0] adc_dout_o,
    output logic                         adc_valid_o
);

    logic [NCHAN*NSAMP*NBITS-1:0] dout_d;

    if (NBITS > RFDC_BITS) begin : g_bad_nbits
        $error("NBITS exceeds the converter lane width");
    end

    // keep the top NBITS of every lane, zero for channels switched off
    always_comb begin
        for (int ch = 0; ch < NCHAN; ch++) begin
            for (int s = 0; s < NSAMP; s++) begin
                dout_d[NBITS*(NSAMP*ch+s) +: NBITS] = chan_en_i[ch] ?
                    adc_tdata_i[NSAMP*ch+s][RFDC_BITS-1 -: NBITS] : '0;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        adc_dout_o <= dout_d;
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            adc_valid_o <= 1'b0;
        end else begin
            adc_valid_o <= adc_tvalid_i;
        end
    end

    // converter lanes must be known whenever they are flagged valid
    assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        adc_tvalid_i |-> !$isunknown(adc_tdata_i));

endmodule

// File: rtl/rfdc_subsys_top.sv
`timescale 1ns/1ps

module rfdc_subsys_top import rfdc_pkg::*; #(
    parameter int NCHAN = 8,
    parameter int NSAMP = 8,
    parameter int NBITS = 12
) (
    input  logic                         wb_clk_i,
    input  logic                         rst_n_i,
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  addr_t                        wb_adr_i,
    input  strb_t                        wb_sel_i,
    input  data_t                        wb_dat_i,
    output data_t                        wb_dat_o,
    output logic                         wb_ack_o,
    output logic                         bridge_err_o,
    input  logic                         sysref_i,
    input  lane_t [NCHAN*NSAMP-1:0]      adc_tdata_i,
    input  logic                         adc_tvalid_i,
    output logic [NCHAN*NSAMP*NBITS-1:0] adc_dout_o,
    output logic                         adc_valid_o
);

    // bridge to slice
    axil_aw_t m_aw;
    logic     m_aw_valid, m_aw_ready;
    axil_w_t  m_w;
    logic     m_w_valid, m_w_ready;
    axil_b_t  m_b;
    logic     m_b_valid, m_b_ready;
    axil_ar_t m_ar;
    logic     m_ar_valid, m_ar_ready;
    axil_r_t  m_r;
    logic     m_r_valid, m_r_ready;

    // slice to register file
    axil_aw_t s_aw;
    logic     s_aw_valid, s_aw_ready;
    axil_w_t  s_w;
    logic     s_w_valid, s_w_ready;
    axil_b_t  s_b;
    logic     s_b_valid, s_b_ready;
    axil_ar_t s_ar;
    logic     s_ar_valid, s_ar_ready;
    axil_r_t  s_r;
    logic     s_r_valid, s_r_ready;

    logic [NCHAN-1:0] chan_en;

    wb_axil_bridge u_bridge (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_sel_i     (wb_sel_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .bridge_err_o (bridge_err_o),
        .aw_o         (m_aw),
        .aw_valid_o   (m_aw_valid),
        .aw_ready_i   (m_aw_ready),
        .w_o          (m_w),
        .w_valid_o    (m_w_valid),
        .w_ready_i    (m_w_ready),
        .b_i          (m_b),
        .b_valid_i    (m_b_valid),
        .b_ready_o    (m_b_ready),
        .ar_o         (m_ar),
        .ar_valid_o   (m_ar_valid),
        .ar_ready_i   (m_ar_ready),
        .r_i          (m_r),
        .r_valid_i    (m_r_valid),
        .r_ready_o    (m_r_ready)
    );

    axil_reg_slice u_slice (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .s_aw_i       (m_aw),
        .s_aw_valid_i (m_aw_valid),
        .s_aw_ready_o (m_aw_ready),
        .s_w_i        (m_w),
        .s_w_valid_i  (m_w_valid),
        .s_w_ready_o  (m_w_ready),
        .s_b_o        (m_b),
        .s_b_valid_o  (m_b_valid),
        .s_b_ready_i  (m_b_ready),
        .s_ar_i       (m_ar),
        .s_ar_valid_i (m_ar_valid),
        .s_ar_ready_o (m_ar_ready),
        .s_r_o        (m_r),
        .s_r_valid_o  (m_r_valid),
        .s_r_ready_i  (m_r_ready),
        .m_aw_o       (s_aw),
        .m_aw_valid_o (s_aw_valid),
        .m_aw_ready_i (s_aw_ready),
        .m_w_o        (s_w),
        .m_w_valid_o  (s_w_valid),
        .m_w_ready_i  (s_w_ready),
        .m_b_i        (s_b),
        .m_b_valid_i  (s_b_valid),
        .m_b_ready_o  (s_b_ready),
        .m_ar_o       (s_ar),
        .m_ar_valid_o (s_ar_valid),
        .m_ar_ready_i (s_ar_ready),
        .m_r_i        (s_r),
        .m_r_valid_i  (s_r_valid),
        .m_r_ready_o  (s_r_ready)
    );

    conv_ctrl_regs #(
        .NCHAN (NCHAN)
    ) u_regs (
        .wb_clk_i   (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .aw_i       (s_aw),
        .aw_valid_i (s_aw_valid),
        .aw_ready_o (s_aw_ready),
        .w_i        (s_w),
        .w_valid_i  (s_w_valid),
        .w_ready_o  (s_w_ready),
        .b_o        (s_b),
        .b_valid_o  (s_b_valid),
        .b_ready_i  (s_b_ready),
        .ar_i       (s_ar),
        .ar_valid_i (s_ar_valid),
        .ar_ready_o (s_ar_ready),
        .r_o        (s_r),
        .r_valid_o  (s_r_valid),
        .r_ready_i  (s_r_ready),
        .sysref_i   (sysref_i),
        .chan_en_o  (chan_en)
    );

    sample_unpack #(
        .NCHAN (NCHAN),
        .NSAMP (NSAMP),
        .NBITS (NBITS)
    ) u_unpack (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .adc_tdata_i  (adc_tdata_i),
        .adc_tvalid_i (adc_tvalid_i),
        .chan_en_i    (chan_en),
        .adc_dout_o   (adc_dout_o),
        .adc_valid_o  (adc_valid_o)
    );

endmodule

// File: test/tb_rfdc_subsys.sv
`timescale 1ns/1ps

module tb_rfdc_subsys import rfdc_pkg::*; ();

    localparam int NCHAN = 8;
    localparam int NSAMP = 8;
    localparam int NBITS = 12;
    localparam int NLANE = NCHAN * NSAMP;
    localparam int NOUT  = NLANE * NBITS;
    localparam int NENT  = 16;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_SAMPLE,
        OP_SYSREF
    } op_t;

    // data is the write word, the channel mask for samples, or the pulse count
    typedef struct packed {
        op_t   kind;
        addr_t addr;
        data_t data;
        strb_t sel;
        data_t exp;
        logic  err;
    } entry_t;

    logic                clk;
    logic                rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    addr_t               wb_adr;
    strb_t               wb_sel;
    data_t               wb_dat_w;
    data_t               wb_dat_r;
    logic                wb_ack;
    logic                bridge_err;
    logic                sysref;
    lane_t [NLANE-1:0]   adc_tdata;
    logic                adc_tvalid;
    logic [NOUT-1:0]     adc_dout;
    logic                adc_valid;

    entry_t tests [NENT];
    integer seed = 32'hacde_a586;
    int     errors = 0;
    int     n_pass = 0;
    int     n_fail = 0;

    rfdc_subsys_top uut (
        .wb_clk_i     (clk),
        .rst_n_i      (rst_n),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_sel_i     (wb_sel),
        .wb_dat_i     (wb_dat_w),
        .wb_dat_o     (wb_dat_r),
        .wb_ack_o     (wb_ack),
        .bridge_err_o (bridge_err),
        .sysref_i     (sysref),
        .adc_tdata_i  (adc_tdata),
        .adc_tvalid_i (adc_tvalid),
        .adc_dout_o   (adc_dout),
        .adc_valid_o  (adc_valid)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    initial begin
        repeat (NENT * 40 + 100) @(posedge clk);
        $display("timeout: the test sequence did not finish in time");
        $display("Checks failed");
        $finish;
    end

    task automatic load_tests();
        tests[0]  = '{OP_READ,   REG_ID,         32'h0,         4'hf, RFDC_ID,       1'b0};
        tests[1]  = '{OP_WRITE,  REG_ID,         32'hdead_beef, 4'hf, 32'h0,         1'b1};
        tests[2]  = '{OP_READ,   REG_ID,         32'h0,         4'hf, RFDC_ID,       1'b0};
        tests[3]  = '{OP_WRITE,  REG_SCRATCH,    32'h1122_3344, 4'hf, 32'h0,         1'b0};
        tests[4]  = '{OP_WRITE,  REG_SCRATCH,    32'haabb_ccdd, 4'h5, 32'h0,         1'b0};
        tests[5]  = '{OP_READ,   REG_SCRATCH,    32'h0,         4'hf, 32'h11bb_33dd, 1'b0};
        tests[6]  = '{OP_READ,   18'h40,         32'h0,         4'hf, 32'h0,         1'b1};
        tests[7]  = '{OP_WRITE,  18'h40,         32'h1234_5678, 4'hf, 32'h0,         1'b1};
        tests[8]  = '{OP_SAMPLE, 18'h0,          32'h0000_00ff, 4'h0, 32'h0,         1'b0};
        tests[9]  = '{OP_WRITE,  REG_CHAN_EN,    32'h0000_005a, 4'hf, 32'h0,         1'b0};
        tests[10] = '{OP_SAMPLE, 18'h0,          32'h0000_005a, 4'h0, 32'h0,         1'b0};
        tests[11] = '{OP_READ,   REG_CHAN_EN,    32'h0,         4'hf, 32'h0000_005a, 1'b0};
        tests[12] = '{OP_SYSREF, 18'h0,          32'd5,         4'h0, 32'h0,         1'b0};
        tests[13] = '{OP_READ,   REG_SYSREF_CNT, 32'h0,         4'hf, 32'd5,         1'b0};
        tests[14] = '{OP_WRITE,  REG_SYSREF_CNT, 32'h0,         4'hf, 32'h0,         1'b1};
        tests[15] = '{OP_READ,   REG_SYSREF_CNT, 32'h0,         4'hf, 32'd5,         1'b0};
    endtask

    task automatic check_value(input string name, input logic [NOUT-1:0] expected,
                               input logic [NOUT-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // lane i belongs to channel i / NSAMP and lands at bit NBITS * i
    function automatic logic [NOUT-1:0] unpack_expected(input lane_t [NLANE-1:0] lanes,
                                                        input logic [NCHAN-1:0] mask);
        logic [NOUT-1:0] res;
        res = '0;
        for (int i = 0; i < NLANE; i++) begin
            if (mask[i / NSAMP]) begin
                res[i*NBITS +: NBITS] = NBITS'(lanes[i] >> (RFDC_BITS - NBITS));
            end
        end
        return res;
    endfunction

    task automatic wb_access(input logic we, input addr_t adr, input strb_t sel,
                             input data_t dat, output data_t rdata, output logic err);
        logic ack_seen;
        err      = 1'b0;
        rdata    = '0;
        ack_seen = 1'b0;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_sel   = sel;
        wb_dat_w = dat;
        while (!ack_seen) begin
            @(posedge clk);
            #1;
            if (bridge_err) err = 1'b1;
            if (wb_ack) begin
                ack_seen = 1'b1;
                rdata    = wb_dat_r;
            end
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // a read error shows up one cycle after the ack
        @(posedge clk);
        #1;
        if (bridge_err) err = 1'b1;
    endtask

    task automatic apply_samples(input logic [NCHAN-1:0] mask);
        lane_t [NLANE-1:0] lanes;
        @(posedge clk);
        #1;
        for (int i = 0; i < NLANE; i++) begin
            lanes[i] = lane_t'($random(seed));
        end
        adc_tdata  = lanes;
        adc_tvalid = 1'b1;
        @(posedge clk);
        #1;
        adc_tvalid = 1'b0;
        adc_tdata  = '0;
        check_value("adc_valid_o", NOUT'(1'b1), NOUT'(adc_valid));
        check_value("adc_dout_o", unpack_expected(lanes, mask), adc_dout);
    endtask

    task automatic pulse_sysref(input int count);
        repeat (count) begin
            @(posedge clk);
            #1;
            sysref = 1'b1;
            @(posedge clk);
            #1;
            sysref = 1'b0;
        end
        @(posedge clk);
    endtask

    initial begin
        entry_t t;
        data_t  rdata;
        logic   err;
        int     errs_before;
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_sel     = '0;
        wb_dat_w   = '0;
        sysref     = 1'b0;
        adc_tdata  = '0;
        adc_tvalid = 1'b0;
        load_tests();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("wb_ack_o", NOUT'(1'b0), NOUT'(wb_ack));
        check_value("bridge_err_o", NOUT'(1'b0), NOUT'(bridge_err));
        check_value("adc_valid_o", NOUT'(1'b0), NOUT'(adc_valid));

        for (int idx = 0; idx < NENT; idx++) begin
            t           = tests[idx];
            errs_before = errors;
            case (t.kind)
                OP_WRITE: begin
                    wb_access(1'b1, t.addr, t.sel, t.data, rdata, err);
                    check_value("bridge_err_o", NOUT'(t.err), NOUT'(err));
                end
                OP_READ: begin
                    wb_access(1'b0, t.addr, t.sel, t.data, rdata, err);
                    check_value("wb_dat_o", NOUT'(t.exp), NOUT'(rdata));
                    check_value("bridge_err_o", NOUT'(t.err), NOUT'(err));
                end
                OP_SAMPLE: apply_samples(t.data[NCHAN-1:0]);
                default:   pulse_sysref(int'(t.data));
            endcase
            if (errors == errs_before) begin
                n_pass++;
                $display("test %0d %s addr %0h ok", idx, t.kind.name(), t.addr);
            end else begin
                n_fail++;
                $display("test %0d %s addr %0h mismatch", idx, t.kind.name(), t.addr);
            end
        end

        $display("tests: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sim.f
rtl/rfdc_pkg.sv
rtl/wb_axil_bridge.sv
rtl/axil_reg_slice.sv
rtl/conv_ctrl_regs.sv
rtl/sample_unpack.sv
rtl/rfdc_subsys_top.sv
test/tb_rfdc_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rfdc_subsys
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
